/* include/schedDefs_defs.svh */
`ifndef SCHED_DEFS_DEFS_SVH
`define SCHED_DEFS_DEFS_SVH

`define NUM_CORES       4
`define TASK_MEM_DEPTH  16
`define TASK_PTR_WIDTH  4
`define REG_WIDTH       16
`define FRAME_WIDTH     84
`define IF_NUM_WIDTH    4
`define FENCE_WIDTH     2
`define OP_WIDTH        2
`define LAT_WIDTH       4
`define SHIFT_WIDTH     4

// Padding up to a full frame word
`define CTRL_PAD_WIDTH  (`FRAME_WIDTH - `FENCE_WIDTH - 2*`NUM_CORES - `IF_NUM_WIDTH \
                         - `NUM_CORES*`REG_WIDTH)
`define INSN_PAD_WIDTH  (`FRAME_WIDTH - `OP_WIDTH - `LAT_WIDTH - `REG_WIDTH)

`define FENCE_NO        2'd0
`define FENCE_ACQ       2'd1
`define FENCE_REL       2'd2

`define OP_ADD          2'd0
`define OP_SUB          2'd1
`define OP_XOR          2'd2
`define OP_SHL          2'd3

`endif

/* logic/schedPkg.sv */
`include "schedDefs_defs.svh"

package schedPkg;

	typedef struct packed {
		logic [`CTRL_PAD_WIDTH-1:0]               pad;
		logic [`NUM_CORES-1:0][`REG_WIDTH-1:0]    r0Value;     // Core 0 in the low word
		logic [`IF_NUM_WIDTH-1:0]                 insnNum;     // Instruction frames that follow
		logic [`NUM_CORES-1:0]                    r0InitVect;
		logic [`NUM_CORES-1:0]                    coreActive;
		logic [`FENCE_WIDTH-1:0]                  fence;
	} ctrlFrame;

	typedef struct packed {
		logic [`INSN_PAD_WIDTH-1:0]  pad;
		logic [`REG_WIDTH-1:0]       imm;
		logic [`LAT_WIDTH-1:0]       latency;     // Zero runs as one cycle
		logic [`OP_WIDTH-1:0]        opcode;
	} insnFrame;

	// One task memory word, read as control or instruction by scheduler state
	typedef union packed {
		ctrlFrame ctrl;
		insnFrame insn;
	} taskFrame;

endpackage

/* logic/taskScheduler.sv */
`include "schedDefs_defs.svh"

module taskScheduler import schedPkg::*; (
	input  logic                                        clk,
	input  logic                                        reset,
	input  logic [`TASK_MEM_DEPTH*`FRAME_WIDTH-1:0]     taskMemory,
	input  logic [`NUM_CORES-1:0]                       ready,
	output logic [`NUM_CORES-1:0]                       start,
	output taskFrame                                    insnData,
	output logic [`NUM_CORES-1:0]                       initR0Vect,
	output logic [`NUM_CORES-1:0][`REG_WIDTH-1:0]       initR0
);

	taskFrame                       taskMem [`TASK_MEM_DEPTH];
	taskFrame                       curFrame;
	taskFrame                       reloadFrame;
	logic [`TASK_PTR_WIDTH-1:0]     framePtr;
	logic [`IF_NUM_WIDTH-1:0]       insnLeft;
	logic [`FENCE_WIDTH-1:0]        fence;
	logic [`NUM_CORES-1:0]          activeVect;
	logic [`NUM_CORES-1:0]          busy;
	logic                           atReload;
	logic                           waitAll;
	logic                           issueInsn;
	logic                           takeCtrl;

	assign busy     = ~ready;
	assign atReload = framePtr == `TASK_PTR_WIDTH'(`TASK_MEM_DEPTH - 1);

	// Reload slot comes straight from the bus while it is being captured
	assign reloadFrame = taskMemory[(`TASK_MEM_DEPTH-1)*`FRAME_WIDTH +: `FRAME_WIDTH];
	assign curFrame    = atReload ? reloadFrame : taskMem[framePtr];

	// ACQ holds everything behind it, REL waits for everything before it
	assign waitAll   = (fence == `FENCE_ACQ) || (curFrame.ctrl.fence == `FENCE_REL);
	assign issueInsn = (insnLeft != '0) && ((activeVect & busy) == '0);
	assign takeCtrl  = (insnLeft == '0) &&
	                   (waitAll ? (busy == '0) : ((busy & curFrame.ctrl.coreActive) == '0));

	always_ff @(posedge clk) begin
		if (atReload) begin
			for (int i = 0; i < `TASK_MEM_DEPTH; i++) begin
				taskMem[i] <= taskMemory[i*`FRAME_WIDTH +: `FRAME_WIDTH];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			framePtr   <= `TASK_PTR_WIDTH'(`TASK_MEM_DEPTH - 1);     // Load memory first
			insnLeft   <= '0;
			fence      <= `FENCE_NO;
			activeVect <= '0;
		end else if (issueInsn) begin
			framePtr <= framePtr + `TASK_PTR_WIDTH'(1);
			insnLeft <= insnLeft - `IF_NUM_WIDTH'(1);
		end else if (takeCtrl) begin
			framePtr   <= framePtr + `TASK_PTR_WIDTH'(1);
			insnLeft   <= curFrame.ctrl.insnNum;
			fence      <= curFrame.ctrl.fence;
			activeVect <= curFrame.ctrl.coreActive;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			start      <= '0;
			initR0Vect <= '0;
		end else begin
			start      <= issueInsn ? activeVect : '0;
			initR0Vect <= takeCtrl ? curFrame.ctrl.r0InitVect : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (issueInsn) begin
			insnData <= curFrame;
		end
		if (takeCtrl) begin
			initR0 <= curFrame.ctrl.r0Value;
		end
	end

endmodule

/* logic/computeCore.sv */
`include "schedDefs_defs.svh"

module computeCore import schedPkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     start,
	input  taskFrame                 insnData,
	input  logic                     initR0Valid,
	input  logic [`REG_WIDTH-1:0]    initR0,
	output logic                     ready,
	output logic                     done,
	output logic [`REG_WIDTH-1:0]    result
);

	insnFrame                   insnIn;
	insnFrame                   insnReg;
	insnFrame                   opInsn;
	logic [`LAT_WIDTH-1:0]      latEff;
	logic [`LAT_WIDTH-1:0]      cnt;
	logic [`REG_WIDTH-1:0]      r0;
	logic [`REG_WIDTH-1:0]      aluOut;
	logic                       busy;
	logic                       finish;

	assign insnIn = insnData.insn;
	assign latEff = (insnIn.latency == '0) ? `LAT_WIDTH'(1) : insnIn.latency;
	assign opInsn = start ? insnIn : insnReg;     // Single-cycle ops finish on start
	assign finish = (start && latEff == `LAT_WIDTH'(1)) || (busy && cnt == `LAT_WIDTH'(1));

	assign ready  = ~(start | busy | done);
	assign result = r0;

	always_comb begin
		case (opInsn.opcode)
			`OP_ADD: aluOut = r0 + opInsn.imm;
			`OP_SUB: aluOut = r0 - opInsn.imm;
			`OP_XOR: aluOut = r0 ^ opInsn.imm;
			default: aluOut = r0 << opInsn.imm[`SHIFT_WIDTH-1:0];
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			cnt  <= '0;
			done <= 1'b0;
			r0   <= '0;
		end else begin
			done <= finish;
			if (finish) begin
				busy <= 1'b0;
				r0   <= aluOut;
			end else if (start) begin
				busy <= 1'b1;
				cnt  <= latEff - `LAT_WIDTH'(1);
			end else if (busy) begin
				cnt <= cnt - `LAT_WIDTH'(1);
			end else if (initR0Valid && !done) begin
				r0 <= initR0;     // Preload only while idle
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			insnReg <= insnIn;
		end
	end

endmodule

/* logic/resultCombiner.sv */
`include "schedDefs_defs.svh"

module resultCombiner (
	input  logic                                     clk,
	input  logic                                     reset,
	input  logic [`NUM_CORES-1:0]                    done,
	input  logic [`NUM_CORES-1:0][`REG_WIDTH-1:0]    result,
	output logic                                     resultValid,
	output logic [`NUM_CORES-1:0]                    resultMask,
	output logic [`REG_WIDTH-1:0]                    resultSum
);

	logic [`REG_WIDTH-1:0] sum;

	always_comb begin
		sum = '0;
		for (int i = 0; i < `NUM_CORES; i++) begin
			if (done[i]) begin
				sum = sum + result[i];     // Wraps at register width
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			resultValid <= 1'b0;
			resultMask  <= '0;
		end else begin
			resultValid <= |done;
			resultMask  <= done;
		end
	end

	always_ff @(posedge clk) begin
		if (|done) begin
			resultSum <= sum;
		end
	end

endmodule

/* logic/coreArray.sv */
`include "schedDefs_defs.svh"

module coreArray import schedPkg::*; (
	input  logic                                        clk,
	input  logic                                        reset,
	input  logic [`TASK_MEM_DEPTH*`FRAME_WIDTH-1:0]     taskMemory,
	output logic                                        resultValid,
	output logic [`NUM_CORES-1:0]                       resultMask,
	output logic [`REG_WIDTH-1:0]                       resultSum
);

	logic [`NUM_CORES-1:0]                      start;
	logic [`NUM_CORES-1:0]                      ready;
	logic [`NUM_CORES-1:0]                      initR0Vect;
	logic [`NUM_CORES-1:0]                      done;
	logic [`NUM_CORES-1:0][`REG_WIDTH-1:0]      initR0;
	logic [`NUM_CORES-1:0][`REG_WIDTH-1:0]      result;
	taskFrame                                   insnData;

	taskScheduler uTaskScheduler (
		.clk        (clk),
		.reset      (reset),
		.taskMemory (taskMemory),
		.ready      (ready),
		.start      (start),
		.insnData   (insnData),
		.initR0Vect (initR0Vect),
		.initR0     (initR0)
	);

	for (genvar i = 0; i < `NUM_CORES; i++) begin : coreGen
		computeCore uCore (
			.clk         (clk),
			.reset       (reset),
			.start       (start[i]),
			.insnData    (insnData),
			.initR0Valid (initR0Vect[i]),
			.initR0      (initR0[i]),
			.ready       (ready[i]),
			.done        (done[i]),
			.result      (result[i])
		);
	end

	resultCombiner uCombiner (
		.clk         (clk),
		.reset       (reset),
		.done        (done),
		.result      (result),
		.resultValid (resultValid),
		.resultMask  (resultMask),
		.resultSum   (resultSum)
	);

endmodule

/* tests/coreArrayAssertions.sv */
module coreArrayAssertions (
	input logic clk,
	input logic reset,
	input logic start,
	input logic ready,
	input logic done,
	input logic initR0Valid
);

	// Issue decided on the cycle before start
	startWhenReady: assert property (@(posedge clk) disable iff (reset) start |-> $past(ready))
		else $error("start issued to a core that was not ready");

	noStartWithInit: assert property (@(posedge clk) disable iff (reset) !(start && initR0Valid))
		else $error("start and R0 init high together");

	donePulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("done held longer than one cycle");

	// A busy core stays not ready through its done cycle
	busyUntilDone: assert property (@(posedge clk) disable iff (reset)
			(!ready && !done) |=> !ready)
		else $error("ready rose before done");

	// Ready comes back only right after done
	readyAfterDone: assert property (@(posedge clk) disable iff (reset) $rose(ready) |-> $past(done))
		else $error("ready rose without a preceding done");

endmodule

bind computeCore coreArrayAssertions uCoreChecks (
	.clk         (clk),
	.reset       (reset),
	.start       (start),
	.ready       (ready),
	.done        (done),
	.initR0Valid (initR0Valid)
);

/* tests/coreArrayTb.sv */
`include "schedDefs_defs.svh"

module coreArrayTb import schedPkg::*; ();

	logic                                       clk;
	logic                                       reset;
	logic [`TASK_MEM_DEPTH*`FRAME_WIDTH-1:0]    taskMemory;
	logic                                       resultValid;
	logic [`NUM_CORES-1:0]                      resultMask;
	logic [`REG_WIDTH-1:0]                      resultSum;

	taskFrame                   prog [`TASK_MEM_DEPTH];
	logic [`REG_WIDTH-1:0]      modelR0 [`NUM_CORES];
	int                         cycle;
	int                         checks;
	int                         errors;

	coreArray u_coreArray (
		.clk         (clk),
		.reset       (reset),
		.taskMemory  (taskMemory),
		.resultValid (resultValid),
		.resultMask  (resultMask),
		.resultSum   (resultSum)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	task automatic tick();
		@(posedge clk);
		#1;
		cycle++;
	endtask

	task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch %s got %h expected %h", name, got, exp);
		end
	endtask

	// Empty control frames everywhere, including the reload slot
	task automatic clearProgram();
		for (int i = 0; i < `TASK_MEM_DEPTH; i++) begin
			prog[i] = '0;
		end
		for (int i = 0; i < `NUM_CORES; i++) begin
			modelR0[i] = '0;
		end
	endtask

	task automatic loadProgram();
		for (int i = 0; i < `TASK_MEM_DEPTH; i++) begin
			taskMemory[i*`FRAME_WIDTH +: `FRAME_WIDTH] = prog[i];
		end
	endtask

	task automatic resetDut();
		reset = 1'b1;
		repeat (2) tick();
		reset = 1'b0;
	endtask

	// Control frame that preloads R0 of every active core
	task automatic putCtrl(input int idx, input logic [1:0] fenceCode, input logic [3:0] active,
			input logic [3:0] count);
		taskFrame f;
		f = '0;
		f.ctrl.fence      = fenceCode;
		f.ctrl.coreActive = active;
		f.ctrl.r0InitVect = active;
		f.ctrl.insnNum    = count;
		for (int i = 0; i < `NUM_CORES; i++) begin
			f.ctrl.r0Value[i] = `REG_WIDTH'($urandom);
			if (active[i]) begin
				modelR0[i] = f.ctrl.r0Value[i];
			end
		end
		prog[idx] = f;
	endtask

	task automatic putInsn(input int idx, input logic [1:0] op, input logic [3:0] lat);
		taskFrame f;
		f = '0;
		f.insn.opcode  = op;
		f.insn.latency = lat;
		f.insn.imm     = `REG_WIDTH'($urandom);
		prog[idx] = f;
	endtask

	function automatic logic [15:0] applyOp(input insnFrame op, input logic [15:0] r);
		case (op.opcode)
			`OP_ADD: return r + op.imm;
			`OP_SUB: return r - op.imm;
			`OP_XOR: return r ^ op.imm;
			default: return r << op.imm[3:0];
		endcase
	endfunction

	task automatic waitResult(output bit ok);
		int n;
		n = 0;
		while (!resultValid && n < 100) begin
			tick();
			n++;
		end
		ok = resultValid;
		assert (ok) else begin
			errors++;
			$display("timeout waiting for resultValid");
		end
	endtask

	// Steps the model for one instruction and checks the matching result pulse
	task automatic expectInsn(input logic [3:0] active, input taskFrame f);
		logic [15:0] sum;
		bit ok;
		sum = '0;
		for (int i = 0; i < `NUM_CORES; i++) begin
			if (active[i]) begin
				modelR0[i] = applyOp(f.insn, modelR0[i]);
				sum = sum + modelR0[i];
			end
		end
		waitResult(ok);
		if (ok) begin
			checkValue("resultMask", 16'(resultMask), 16'(active));
			checkValue("resultSum", resultSum, sum);
			tick();
		end
	endtask

	task automatic singleCoreProgram();
		clearProgram();
		putCtrl(0, `FENCE_NO, 4'b0100, 4'd3);
		putInsn(1, `OP_ADD, 4'd1);
		putInsn(2, `OP_XOR, 4'd1);
		putInsn(3, `OP_SHL, 4'd0);     // Zero latency runs as one
		loadProgram();
		resetDut();
		for (int k = 1; k <= 3; k++) begin
			expectInsn(4'b0100, prog[k]);
		end
	endtask

	task automatic broadcastAll();
		clearProgram();
		putCtrl(0, `FENCE_NO, 4'b1111, 4'd3);
		putInsn(1, `OP_SUB, 4'd2);
		putInsn(2, `OP_ADD, 4'd2);
		putInsn(3, `OP_XOR, 4'd4);
		loadProgram();
		resetDut();
		for (int k = 1; k <= 3; k++) begin
			expectInsn(4'b1111, prog[k]);
		end
	endtask

	task automatic latencySweep();
		int n;
		int t0;
		bit ok;
		clearProgram();
		putCtrl(0, `FENCE_NO, 4'b0010, 4'd3);
		putInsn(1, `OP_ADD, 4'd1);
		putInsn(2, `OP_ADD, 4'd3);
		putInsn(3, `OP_ADD, 4'd7);
		loadProgram();
		resetDut();
		for (int k = 1; k <= 3; k++) begin
			n = 0;
			while (!u_coreArray.start[1] && n < 100) begin
				tick();
				n++;
			end
			assert (u_coreArray.start[1]) else begin
				errors++;
				$display("timeout waiting for start on core 1");
			end
			t0 = cycle;
			waitResult(ok);
			checkValue("resultValid delay", 16'(cycle - t0), 16'(prog[k].insn.latency + 1));
			expectInsn(4'b0010, prog[k]);
		end
	endtask

	// Second group runs its short ops while core 0 is still busy
	task automatic fenceNoOverlap();
		clearProgram();
		putCtrl(0, `FENCE_NO, 4'b0001, 4'd1);
		putInsn(1, `OP_ADD, 4'd15);
		putCtrl(2, `FENCE_NO, 4'b0010, 4'd2);
		putInsn(3, `OP_XOR, 4'd1);
		putInsn(4, `OP_SUB, 4'd1);
		loadProgram();
		resetDut();
		expectInsn(4'b0010, prog[3]);
		expectInsn(4'b0010, prog[4]);
		expectInsn(4'b0001, prog[1]);
	endtask

	// REL waits for core 0, ACQ on core 1 holds back core 3
	task automatic fenceAcqRel();
		clearProgram();
		putCtrl(0, `FENCE_NO, 4'b0001, 4'd1);
		putInsn(1, `OP_ADD, 4'd12);
		putCtrl(2, `FENCE_REL, 4'b0100, 4'd1);
		putInsn(3, `OP_XOR, 4'd1);
		putCtrl(4, `FENCE_ACQ, 4'b0010, 4'd1);
		putInsn(5, `OP_ADD, 4'd12);
		putCtrl(6, `FENCE_NO, 4'b1000, 4'd1);
		putInsn(7, `OP_SUB, 4'd1);
		loadProgram();
		resetDut();
		expectInsn(4'b0001, prog[1]);
		expectInsn(4'b0100, prog[3]);
		expectInsn(4'b0010, prog[5]);
		expectInsn(4'b1000, prog[7]);
	endtask

	// New program lands in memory only at the next pass of the reload slot
	task automatic reloadPickup();
		taskFrame oldFrame;
		clearProgram();
		putCtrl(0, `FENCE_NO, 4'b0001, 4'd2);
		putInsn(1, `OP_ADD, 4'd2);
		putInsn(2, `OP_SUB, 4'd2);
		loadProgram();
		resetDut();
		expectInsn(4'b0001, prog[1]);
		oldFrame = prog[2];
		for (int i = 0; i < `TASK_MEM_DEPTH; i++) begin
			prog[i] = '0;
		end
		putCtrl(0, `FENCE_NO, 4'b1000, 4'd2);
		putInsn(1, `OP_XOR, 4'd3);
		putInsn(2, `OP_SHL, 4'd1);
		loadProgram();
		expectInsn(4'b0001, oldFrame);
		expectInsn(4'b1000, prog[1]);
		expectInsn(4'b1000, prog[2]);
	endtask

	initial begin
		reset = 1'b1;
		taskMemory = '0;
		cycle = 0;
		checks = 0;
		errors = 0;
		void'($urandom(64));
		singleCoreProgram();
		broadcastAll();
		latencySweep();
		fenceNoOverlap();
		fenceAcqRel();
		reloadPickup();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* build.f */
+incdir+include
logic/schedPkg.sv
logic/taskScheduler.sv
logic/computeCore.sv
logic/resultCombiner.sv
logic/coreArray.sv
tests/coreArrayAssertions.sv
tests/coreArrayTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the core array testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module coreArrayTb -o coreArraySim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/coreArraySim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
	exit 0
fi
exit 1
